// File: run.sh
#!/bin/sh
set -e

verilator --binary --timing -Wno-fatal --top-module tb_exec -f src.f -o sim_exec
./obj_dir/sim_exec | tee sim.log

if grep -q "^Test OK$" sim.log; then
   exit 0
else
   echo "simulation did not pass, see sim.log"
   exit 1
fi

// File: src.f
verilog/exec_pkg.sv
verilog/isn_decode.sv
verilog/op_fifo.sv
verilog/alu_cc.sv
verilog/exec_top.sv
test/clk_gen.sv
test/tb_exec.sv

// File: test/clk_gen.sv
// free-running clock for the execute unit testbench
// period is set by the instantiating testbench

module clk_gen
#(
   parameter int period = 40
)
(
   output logic clk
);

   initial clk = 1'b0;

   always #(period / 2) clk = ~clk;

endmodule

// File: test/exec_golden.txt
// columns: isn ss_data dd_data result cc(nzvc) latch_cc, all hex
// vectors are applied and checked in this order; codes carry between lines
0B41 0000 1234 1234 0 1  // adc, held codes zero after reset
0DC1 0000 0000 0000 4 1  // sxt with n clear
1001 8000 1111 8000 8 1  // mov
6001 7FFF 0001 8000 A 1  // add overflow
6001 8000 8000 0000 7 1  // add carry and overflow
5001 8001 0100 8101 9 1  // bis keeps c
2042 0001 0002 FFFF 9 1  // cmp borrow
2042 8000 0001 7FFF 2 1  // cmp overflow
E001 0003 0001 FFFE 9 1  // sub borrow
E001 0001 8000 7FFF 2 1  // sub overflow
3001 00F0 0F0F 0000 4 1  // bit
4001 00FF ABCD AB00 8 1  // bic
7801 FFFF FFFF 0000 4 1  // xor
0A01 0000 1234 0000 4 1  // clr
0A41 0000 00FF FF00 9 1  // com
0A81 0000 7FFF 8000 B 1  // inc overflow
0AC1 0000 8000 7FFF 3 1  // dec overflow
0B01 0000 8000 8000 B 1  // neg of most negative
0B01 0000 0000 0000 4 1  // neg zero
0B01 0000 0001 FFFF 9 1  // neg one
0C81 0000 8001 C000 9 1  // asr
0CC1 0000 4001 8002 A 1  // asl
0C01 0000 0003 0001 3 1  // ror with c clear
0C41 0000 8000 0001 3 1  // rol with c set
00C1 0000 12F0 F012 0 1  // swab
00BF 0000 0000 0000 F 1  // scc all
00A6 0000 0000 0000 9 1  // ccc z and v
0B41 0000 FFFF 0000 5 1  // adc with c set
0B81 0000 0000 FFFF 9 1  // sbc with c set
0C01 0000 0002 8001 A 1  // ror with c set
0DC1 0000 0000 FFFF 8 1  // sxt with n set
00A8 0000 0000 0000 0 1  // cln
00B1 0000 0000 0000 1 1  // sec
0100 1111 2222 0000 1 0  // br, not handled here
7000 1111 2222 0000 1 0  // mul, not handled here
0B81 0000 8000 7FFF 2 1  // sbc still sees c set

// File: test/tb_exec.sv
// testbench for the streaming execute unit
// replays the golden vectors with random request gaps and result stalls
// and checks every result, its codes and latch flag in input order

module tb_exec;
   import exec_pkg::*;

   localparam int n_vec         = 36;
   localparam int fifo_depth    = 4;
   localparam int clk_period    = 40;
   localparam int watchdog_time = n_vec * (fifo_depth + 8) * clk_period * 4;

   logic         clk;
   logic         reset;
   exec_req_t    req;
   logic         req_valid;
   logic         req_ready;
   exec_result_t res;
   logic         res_valid;
   logic         res_ready;

   // six words per vector: isn, ss, dd, result, cc, latch_cc
   logic [15:0]  golden [0:n_vec*6-1];
   int           checked = 0;
   int           sent;

   clk_gen #(.period(clk_period)) clk_i
   (
      .clk (clk)
   );

   exec_top #(.fifo_depth(fifo_depth)) dut_i
   (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .res       (res),
      .res_valid (res_valid),
      .res_ready (res_ready)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
         fail_run($sformatf("ERR %s: expected %h, actual %h", name, expected, actual));
   endtask

   task automatic present_vector(input int idx);
      req.isn     <= golden[idx*6];
      req.ss_data <= golden[idx*6+1];
      req.dd_data <= golden[idx*6+2];
      req_valid   <= 1'b1;
   endtask

   // one clock of the request side; called right after a rising edge
   task automatic drive_cycle;
      logic taken;
      taken = req_valid && req_ready;
      // nothing may come out before the first request goes in
      if (sent == 0)
         check_equal("idle res_valid", 32'd0, 32'(res_valid));
      if (taken)
         sent = sent + 1;
      if (taken || !req_valid)
      begin
         if (sent < n_vec && $urandom_range(3) != 0)
            present_vector(sent);
         else
            req_valid <= 1'b0;
      end
   endtask

   // scoreboard checks results against the golden lines in order
   always @(posedge clk)
   begin
      if (reset)
         checked <= 0;
      else if (res_valid && res_ready)
      begin
         if (checked >= n_vec)
            fail_run("a result arrived after the last golden vector was checked");
         else
         begin
            check_equal($sformatf("vec %0d result", checked),
                        32'(golden[checked*6+3]), 32'(res.result));
            check_equal($sformatf("vec %0d cc", checked),
                        32'(golden[checked*6+4]), 32'(res.cc));
            check_equal($sformatf("vec %0d latch_cc", checked),
                        32'(golden[checked*6+5]), 32'(res.latch_cc));
            checked <= checked + 1;
         end
      end
   end

   initial
   begin
      #(watchdog_time);
      fail_run("timeout: not all results arrived before the watchdog expired");
   end

   initial
   begin
      reset     = 1'b1;
      req       = '0;
      req_valid = 1'b0;
      res_ready = 1'b0;
      sent      = 0;
      void'($urandom(32'h88e3));
      $readmemh("test/exec_golden.txt", golden);

      repeat (2) @(posedge clk);
      check_equal("req_ready in reset", 32'd0, 32'(req_ready));
      reset <= 1'b0;

      while (checked < n_vec)
      begin
         @(posedge clk);
         res_ready <= ($urandom_range(1) == 1);
         drive_cycle();
      end

      // drain with the output open so a duplicate result trips the scoreboard
      res_ready <= 1'b1;
      repeat (fifo_depth + 4) @(posedge clk);
      // empty pipeline takes requests again
      check_equal("idle req_ready", 32'd1, 32'(req_ready));

      $display("Test OK");
      $finish;
   end

endmodule

// File: verilog/alu_cc.sv
// consumer stage: word alu with the n/z/v/c register
// computes result and new codes per pdp-11 rules and registers them
// in a single output slot; held codes update when an op is taken

module alu_cc
(
   input  logic                   clk,
   input  logic                   reset,
   input  exec_pkg::dec_op_t      op,
   input  logic                   op_valid,
   output logic                   op_ready,
   output exec_pkg::exec_result_t res,
   output logic                   res_valid,
   input  logic                   res_ready
);
   import exec_pkg::*;

   cc_t              cc_q;
   cc_t              cc_mask;
   cc_t              new_cc;
   word_t            src;
   word_t            dst;
   word_t            alu_r;
   logic [word_w:0]  add_sum;
   logic             r_n;
   logic             r_z;
   logic             latch_w;
   logic             take;
   exec_result_t     next_res;

   assign src     = op.ss_data;
   assign dst     = op.dd_data;
   assign cc_mask = op.cc_mask;
   assign add_sum = {1'b0, src} + {1'b0, dst};

   always_comb
   begin
      case (op.op)
         op_mov:  alu_r = src;
         op_cmp:  alu_r = src - dst;
         op_bit:  alu_r = src & dst;
         op_bic:  alu_r = ~src & dst;
         op_bis:  alu_r = src | dst;
         op_add:  alu_r = add_sum[word_w-1:0];
         op_sub:  alu_r = dst - src;
         op_xor:  alu_r = src ^ dst;
         op_clr:  alu_r = '0;
         op_com:  alu_r = ~dst;
         op_inc:  alu_r = dst + 1'b1;
         op_dec:  alu_r = dst - 1'b1;
         op_neg:  alu_r = -dst;
         op_adc:  alu_r = dst + word_t'(cc_q.c);
         op_sbc:  alu_r = dst - word_t'(cc_q.c);
         op_tst:  alu_r = dst;
         op_ror:  alu_r = {cc_q.c, dst[word_w-1:1]};
         op_rol:  alu_r = {dst[word_w-2:0], cc_q.c};
         op_asr:  alu_r = {dst[word_w-1], dst[word_w-1:1]};
         op_asl:  alu_r = {dst[word_w-2:0], 1'b0};
         op_swab: alu_r = {dst[word_w/2-1:0], dst[word_w-1:word_w/2]};
         op_sxt:  alu_r = {word_w{cc_q.n}};
         default: alu_r = '0;
      endcase
   end

   assign r_n = alu_r[word_w-1];
   assign r_z = (alu_r == '0);

   always_comb
   begin
      new_cc   = cc_q;
      new_cc.n = r_n;
      new_cc.z = r_z;
      latch_w  = 1'b1;
      case (op.op)
         op_mov, op_bit, op_bic, op_bis, op_xor:
            new_cc.v = 1'b0;
         op_cmp:
         begin
            new_cc.v = (src[word_w-1] ^ dst[word_w-1]) & ~(dst[word_w-1] ^ r_n);
            new_cc.c = (src < dst);
         end
         op_sub:
         begin
            new_cc.v = (src[word_w-1] ^ dst[word_w-1]) & ~(src[word_w-1] ^ r_n);
            new_cc.c = (dst < src);
         end
         op_add:
         begin
            new_cc.v = ~(src[word_w-1] ^ dst[word_w-1]) & (src[word_w-1] ^ r_n);
            new_cc.c = add_sum[word_w];
         end
         op_clr, op_tst:
         begin
            new_cc.v = 1'b0;
            new_cc.c = 1'b0;
         end
         op_com:
         begin
            new_cc.v = 1'b0;
            new_cc.c = 1'b1;
         end
         op_inc:
            new_cc.v = (alu_r == word_msb);
         op_dec:
            new_cc.v = (alu_r == word_max);
         op_neg:
         begin
            new_cc.v = (alu_r == word_msb);
            new_cc.c = ~r_z;
         end
         op_adc:
         begin
            new_cc.v = cc_q.c & (alu_r == word_msb);
            new_cc.c = cc_q.c & r_z;
         end
         op_sbc:
         begin
            new_cc.v = cc_q.c & (alu_r == word_max);
            new_cc.c = cc_q.c & (alu_r == '1);
         end
         // bit shifted out goes to c, v flags a sign change
         op_ror, op_asr:
         begin
            new_cc.c = dst[0];
            new_cc.v = r_n ^ dst[0];
         end
         op_rol, op_asl:
         begin
            new_cc.c = dst[word_w-1];
            new_cc.v = r_n ^ dst[word_w-1];
         end
         op_swab:
         begin
            new_cc.n = alu_r[word_w/2-1];
            new_cc.z = (alu_r[word_w/2-1:0] == '0);
            new_cc.v = 1'b0;
            new_cc.c = 1'b0;
         end
         op_sxt:
         begin
            new_cc.n = cc_q.n;
            new_cc.z = ~cc_q.n;
            new_cc.v = 1'b0;
         end
         op_ccc:
            new_cc = cc_t'(cc_q & ~cc_mask);
         op_scc:
            new_cc = cc_t'(cc_q | cc_mask);
         default:
         begin
            new_cc  = cc_q;
            latch_w = 1'b0;
         end
      endcase
   end

   assign next_res.result   = alu_r;
   assign next_res.cc       = new_cc;
   assign next_res.latch_cc = latch_w;

   assign op_ready = ~res_valid | res_ready;
   assign take     = op_valid & op_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cc_q      <= '0;
         res_valid <= 1'b0;
      end
      else
      begin
         if (take)
         begin
            res_valid <= 1'b1;
            if (latch_w)
               cc_q <= new_cc;
         end
         else if (res_ready)
            res_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (take)
         res <= next_res;
   end

endmodule

// File: verilog/exec_pkg.sv
// shared types for the streaming execute pipeline
// widths, alu opcodes and the structs passed between the stages
// modules import it inside their body and use scoped names in port lists

package exec_pkg;

   localparam int word_w = 16;

   typedef logic [word_w-1:0] word_t;

   // overflow boundaries for inc, dec, neg, adc and sbc
   localparam word_t word_msb = {1'b1, {(word_w - 1){1'b0}}};
   localparam word_t word_max = {1'b0, {(word_w - 1){1'b1}}};

   // processor condition codes with n in the top bit as in the psw
   typedef struct packed {
      logic n;
      logic z;
      logic v;
      logic c;
   } cc_t;

   typedef enum logic [4:0] {
      op_mov,
      op_cmp,
      op_bit,
      op_bic,
      op_bis,
      op_add,
      op_sub,
      op_xor,
      op_clr,
      op_com,
      op_inc,
      op_dec,
      op_neg,
      op_adc,
      op_sbc,
      op_tst,
      op_ror,
      op_rol,
      op_asr,
      op_asl,
      op_swab,
      op_sxt,
      op_ccc,
      op_scc,
      op_none
   } alu_op_e;

   // instruction word with its fetched operands
   typedef struct packed {
      word_t isn;
      word_t ss_data;
      word_t dd_data;
   } exec_req_t;

   // cc_mask only meaningful for ccc and scc
   typedef struct packed {
      alu_op_e    op;
      logic [3:0] cc_mask;
      word_t      ss_data;
      word_t      dd_data;
   } dec_op_t;

   typedef struct packed {
      word_t result;
      cc_t   cc;
      logic  latch_cc;
   } exec_result_t;

endpackage

// File: verilog/exec_top.sv
// streaming execute unit: decode -> op fifo -> alu with condition codes
// request and result ports are valid/ready; results leave in input order
// fifo_depth sets how many decoded ops can wait for the alu

module exec_top
#(
   parameter int fifo_depth = 4
)
(
   input  logic                   clk,
   input  logic                   reset,
   input  exec_pkg::exec_req_t    req,
   input  logic                   req_valid,
   output logic                   req_ready,
   output exec_pkg::exec_result_t res,
   output logic                   res_valid,
   input  logic                   res_ready
);
   import exec_pkg::*;

   dec_op_t dec;
   logic    dec_valid;
   logic    dec_ready;
   dec_op_t op;
   logic    op_valid;
   logic    op_ready;

   isn_decode decode_i
   (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .dec       (dec),
      .dec_valid (dec_valid),
      .dec_ready (dec_ready)
   );

   op_fifo #(.fifo_depth(fifo_depth)) fifo_i
   (
      .clk       (clk),
      .reset     (reset),
      .in_data   (dec),
      .in_valid  (dec_valid),
      .in_ready  (dec_ready),
      .out_data  (op),
      .out_valid (op_valid),
      .out_ready (op_ready)
   );

   alu_cc alu_i
   (
      .clk       (clk),
      .reset     (reset),
      .op        (op),
      .op_valid  (op_valid),
      .op_ready  (op_ready),
      .res       (res),
      .res_valid (res_valid),
      .res_ready (res_ready)
   );

endmodule

// File: verilog/isn_decode.sv
// producer stage: classifies a pdp-11 instruction word into an alu opcode
// and holds the decoded operation in a one-entry valid/ready register
// the register refills in the cycle it drains

module isn_decode
(
   input  logic                 clk,
   input  logic                 reset,
   input  exec_pkg::exec_req_t  req,
   input  logic                 req_valid,
   output logic                 req_ready,
   output exec_pkg::dec_op_t    dec,
   output logic                 dec_valid,
   input  logic                 dec_ready
);
   import exec_pkg::*;

   alu_op_e op_kind;
   dec_op_t dec_next;
   logic    running;
   logic    load;

   always_comb
   begin
      op_kind = op_none;
      case (req.isn[15:12])
         4'o01: op_kind = op_mov;
         4'o02: op_kind = op_cmp;
         4'o03: op_kind = op_bit;
         4'o04: op_kind = op_bic;
         4'o05: op_kind = op_bis;
         4'o06: op_kind = op_add;
         4'o16: op_kind = op_sub;
         4'o07:
         begin
            if (req.isn[11:9] == 3'o4)
               op_kind = op_xor;
         end
         4'o00:
         begin
            case (req.isn[11:6])
               6'o03: op_kind = op_swab;
               6'o50: op_kind = op_clr;
               6'o51: op_kind = op_com;
               6'o52: op_kind = op_inc;
               6'o53: op_kind = op_dec;
               6'o54: op_kind = op_neg;
               6'o55: op_kind = op_adc;
               6'o56: op_kind = op_sbc;
               6'o57: op_kind = op_tst;
               6'o60: op_kind = op_ror;
               6'o61: op_kind = op_rol;
               6'o62: op_kind = op_asr;
               6'o63: op_kind = op_asl;
               6'o67: op_kind = op_sxt;
               6'o02:
               begin
                  // 00024x/25x clear, 00026x/27x set
                  if (req.isn[5:4] == 2'b10)
                     op_kind = op_ccc;
                  else if (req.isn[5:4] == 2'b11)
                     op_kind = op_scc;
               end
               default: op_kind = op_none;
            endcase
         end
         default: op_kind = op_none;
      endcase
   end

   assign dec_next.op      = op_kind;
   assign dec_next.cc_mask = (op_kind == op_ccc || op_kind == op_scc) ? req.isn[3:0] : 4'b0;
   assign dec_next.ss_data = req.ss_data;
   assign dec_next.dd_data = req.dd_data;

   // no intake in the first cycle out of reset
   assign req_ready = running & (~dec_valid | dec_ready);
   assign load      = req_valid & req_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         running   <= 1'b0;
         dec_valid <= 1'b0;
      end
      else
      begin
         running <= 1'b1;
         if (load)
            dec_valid <= 1'b1;
         else if (dec_ready)
            dec_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (load)
         dec <= dec_next;
   end

endmodule

// File: verilog/op_fifo.sv
// circular fifo of decoded operations between decode and alu
// fifo_depth must be a power of two so the pointers wrap by themselves
// a write is visible at the output from the next cycle on

module op_fifo
#(
   parameter int fifo_depth = 4
)
(
   input  logic              clk,
   input  logic              reset,
   input  exec_pkg::dec_op_t in_data,
   input  logic              in_valid,
   output logic              in_ready,
   output exec_pkg::dec_op_t out_data,
   output logic              out_valid,
   input  logic              out_ready
);
   import exec_pkg::*;

   localparam int ptr_w = $clog2(fifo_depth);

   dec_op_t          mem [fifo_depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w:0]   count;
   logic             push;
   logic             pop;

   assign in_ready  = (count != (ptr_w + 1)'(fifo_depth));
   assign out_valid = (count != '0);
   assign out_data  = mem[rd_ptr];

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // occupancy holds when both happen
         if (push & ~pop)
            count <= count + 1'b1;
         else if (pop & ~push)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_data;
   end

endmodule
